//--- src/stopw_pkg.sv
`default_nettype none

package stopw_pkg;

  localparam int DIGIT_W = 4;

  // One BCD digit.
  typedef logic [DIGIT_W-1:0] digit_t;

  // Wrap limits per digit.
  localparam digit_t TENTH_MAX = 4'd9;
  localparam digit_t SEC_MAX   = 4'd9;
  localparam digit_t TSEC_MAX  = 4'd5;
  localparam digit_t MIN_MAX   = 4'd9;

  // Set-mode states, walked tenths first and minutes last.
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    CHG_MIN   = 3'd1,
    CHG_TSEC  = 3'd2,
    CHG_SEC   = 3'd3,
    CHG_TENTH = 3'd4
  } set_state_t;

endpackage

`default_nettype wire

//--- src/stopw_bus_pkg.sv
`default_nettype none

package stopw_bus_pkg;

  localparam int WB_AW = 2;
  localparam int WB_DW = 16;

  // Register map.
  localparam logic [WB_AW-1:0] ADDR_TIME   = 2'd0;
  localparam logic [WB_AW-1:0] ADDR_STATUS = 2'd1;
  localparam logic [WB_AW-1:0] ADDR_CTRL   = 2'd2;

  // Status and control bit positions.
  localparam int ST_STATE_LSB   = 0;
  localparam int ST_RUN_BIT     = 3;
  localparam int ST_PASSED_BIT  = 4;
  localparam int CTRL_CLEAR_BIT = 0;

endpackage

`default_nettype wire

//--- src/stopw_button_sync.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_button_sync (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic btn_i,
  output logic pulse_o
);

  logic [1:0] sync_q;
  logic       prev_q;
  logic       pulse_q;

  // Two synchroniser stages, then the edge register.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      sync_q  <= 2'b00;
      prev_q  <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], btn_i};
      prev_q  <= sync_q[1];
      pulse_q <= sync_q[1] & ~prev_q;
    end
  end

  assign pulse_o = pulse_q;

endmodule

`default_nettype wire

//--- src/stopw_finstate.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_finstate import stopw_pkg::*; (
  input  logic       clk_i,
  input  logic       rstn_i,
  input  logic       dev_run_i,
  input  logic       set_i,
  input  logic       change_i,
  output set_state_t state_value_o,
  output logic       inc_this_o,
  output logic       passed_all_o
);

  set_state_t state_q;
  set_state_t state_d;

  always_comb begin
    state_d = state_q;
    if (dev_run_i) begin
      // Running forces the machine back to idle.
      state_d = IDLE;
    end else if (set_i) begin
      case (state_q)
        IDLE:      state_d = CHG_TENTH;
        CHG_TENTH: state_d = CHG_SEC;
        CHG_SEC:   state_d = CHG_TSEC;
        CHG_TSEC:  state_d = CHG_MIN;
        CHG_MIN:   state_d = IDLE;
        default:   state_d = IDLE;
      endcase
    end else begin
      case (state_q)
        IDLE, CHG_TENTH, CHG_SEC, CHG_TSEC, CHG_MIN: state_d = state_q;
        default:                                     state_d = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_value_o = state_q;

  // Change only counts inside one of the digit states.
  assign inc_this_o = change_i & ~dev_run_i & (state_q != IDLE);

  // Full pass, seen in the cycle that leaves minutes.
  assign passed_all_o = set_i & ~dev_run_i & (state_q == CHG_MIN);

endmodule

`default_nettype wire

//--- src/stopw_run_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_run_ctrl #(
  parameter int TICK_DIV = 10_000_000
) (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic start_i,
  input  logic idle_i,
  output logic running_o,
  output logic tick_o
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

  logic             running_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      running_q <= 1'b0;
    end else if (start_i && idle_i) begin
      running_q <= ~running_q;
    end
  end

  // Prescaler holds at zero while stopped.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q <= '0;
    end else if (!running_q || cnt_q == CNT_LAST) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign running_o = running_q;
  assign tick_o    = running_q & (cnt_q == CNT_LAST);

endmodule

`default_nettype wire

//--- src/stopw_digit_counter.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_digit_counter import stopw_pkg::*; #(
  parameter digit_t MAX = TENTH_MAX
) (
  input  logic   clk_i,
  input  logic   rstn_i,
  input  logic   clear_i,
  input  logic   inc_i,
  input  logic   set_inc_i,
  output digit_t digit_o,
  output logic   carry_o
);

  digit_t digit_q;
  logic   at_max;

  assign at_max = (digit_q == MAX);

  // Clear wins over any increment.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      digit_q <= '0;
    end else if (clear_i) begin
      digit_q <= '0;
    end else if (inc_i || set_inc_i) begin
      if (at_max) begin
        digit_q <= '0;
      end else begin
        digit_q <= digit_q + 1'b1;
      end
    end
  end

  assign digit_o = digit_q;

  // Setting a digit wraps in place, only counting carries.
  assign carry_o = inc_i & at_max;

endmodule

`default_nettype wire

//--- src/stopw_wb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_wb_regs import stopw_pkg::*, stopw_bus_pkg::*; (
  input  logic             clk_i,
  input  logic             rstn_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  logic [WB_AW-1:0] wb_adr_i,
  input  logic [WB_DW-1:0] wb_dat_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o,
  input  digit_t [3:0]     time_i,
  input  set_state_t       state_i,
  input  logic             running_i,
  input  logic             passed_all_i,
  output logic             clear_o
);

  logic             ack_q;
  logic             passed_q;
  logic             clear_q;
  logic [WB_DW-1:0] dat_q;
  logic [WB_DW-1:0] status;
  logic             req;
  logic             rd_req;
  logic             wr_req;

  assign req    = wb_cyc_i & wb_stb_i & ~ack_q;
  assign rd_req = req & ~wb_we_i;
  assign wr_req = req & wb_we_i;

  always_comb begin
    status = '0;
    status[ST_STATE_LSB +: 3] = state_i;
    status[ST_RUN_BIT]        = running_i;
    status[ST_PASSED_BIT]     = passed_q;
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      ack_q    <= 1'b0;
      clear_q  <= 1'b0;
      passed_q <= 1'b0;
    end else begin
      ack_q   <= req;
      clear_q <= wr_req & (wb_adr_i == ADDR_CTRL) & wb_dat_i[CTRL_CLEAR_BIT] & ~running_i;
      // A new pass beats a status read in the same cycle.
      if (passed_all_i) begin
        passed_q <= 1'b1;
      end else if (rd_req && wb_adr_i == ADDR_STATUS) begin
        passed_q <= 1'b0;
      end
    end
  end

  // Read data, valid with ack.
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      case (wb_adr_i)
        ADDR_TIME:   dat_q <= time_i;
        ADDR_STATUS: dat_q <= status;
        default:     dat_q <= '0;
      endcase
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;
  assign clear_o  = clear_q;

endmodule

`default_nettype wire

//--- src/stopw_top.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_top import stopw_pkg::*, stopw_bus_pkg::*; #(
  parameter int TICK_DIV = 10_000_000
) (
  input  logic             clk_i,
  input  logic             rstn_i,
  input  logic             btn_start_i,
  input  logic             btn_set_i,
  input  logic             btn_change_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  logic [WB_AW-1:0] wb_adr_i,
  input  logic [WB_DW-1:0] wb_dat_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o,
  output logic             run_o,
  output digit_t [3:0]     time_o
);

  logic         start_p;
  logic         set_p;
  logic         change_p;
  logic         running;
  logic         tick;
  set_state_t   state_value;
  logic         inc_this;
  logic         passed_all;
  logic         clear;
  logic         carry_tenth;
  logic         carry_sec;
  logic         carry_tsec;
  digit_t [3:0] digits;

  stopw_button_sync u_sync_start (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .btn_i  (btn_start_i),
    .pulse_o(start_p)
  );

  stopw_button_sync u_sync_set (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .btn_i  (btn_set_i),
    .pulse_o(set_p)
  );

  stopw_button_sync u_sync_change (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .btn_i  (btn_change_i),
    .pulse_o(change_p)
  );

  stopw_finstate u_finstate (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .dev_run_i    (running),
    .set_i        (set_p),
    .change_i     (change_p),
    .state_value_o(state_value),
    .inc_this_o   (inc_this),
    .passed_all_o (passed_all)
  );

  stopw_run_ctrl #(
    .TICK_DIV(TICK_DIV)
  ) u_run_ctrl (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .start_i  (start_p),
    .idle_i   (state_value == IDLE),
    .running_o(running),
    .tick_o   (tick)
  );

  // Digit 0 is tenths, digit 3 is minutes.
  stopw_digit_counter #(.MAX(TENTH_MAX)) u_tenth (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .clear_i  (clear),
    .inc_i    (tick),
    .set_inc_i(inc_this && state_value == CHG_TENTH),
    .digit_o  (digits[0]),
    .carry_o  (carry_tenth)
  );

  stopw_digit_counter #(.MAX(SEC_MAX)) u_sec (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .clear_i  (clear),
    .inc_i    (carry_tenth),
    .set_inc_i(inc_this && state_value == CHG_SEC),
    .digit_o  (digits[1]),
    .carry_o  (carry_sec)
  );

  stopw_digit_counter #(.MAX(TSEC_MAX)) u_tsec (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .clear_i  (clear),
    .inc_i    (carry_sec),
    .set_inc_i(inc_this && state_value == CHG_TSEC),
    .digit_o  (digits[2]),
    .carry_o  (carry_tsec)
  );

  // Minutes simply wrap at the top of the range.
  stopw_digit_counter #(.MAX(MIN_MAX)) u_min (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .clear_i  (clear),
    .inc_i    (carry_tsec),
    .set_inc_i(inc_this && state_value == CHG_MIN),
    .digit_o  (digits[3]),
    .carry_o  ()
  );

  stopw_wb_regs u_wb_regs (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .time_i      (digits),
    .state_i     (state_value),
    .running_i   (running),
    .passed_all_i(passed_all),
    .clear_o     (clear)
  );

  assign run_o  = running;
  assign time_o = digits;

endmodule

`default_nettype wire

//--- verification/stopw_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge.
  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/stopw_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_asserts import stopw_pkg::*; (
  input logic       clk_i,
  input logic       rstn_i,
  input set_state_t state_i,
  input logic       running_i,
  input logic       passed_all_i,
  input logic       wb_ack_i
);

  int fail_count = 0;

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("Wishbone ack held for more than one cycle");
      fail_count++;
    end

  // Start is only honoured in idle, so running keeps the set machine there.
  idle_while_running: assert property (@(posedge clk_i) disable iff (!rstn_i)
    running_i |-> state_i == IDLE)
    else begin
      $error("Set machine left idle while the watch runs");
      fail_count++;
    end

  passed_on_min_exit: assert property (@(posedge clk_i) disable iff (!rstn_i)
    passed_all_i |-> state_i == CHG_MIN ##1 state_i == IDLE)
    else begin
      $error("Pass flag raised outside the exit from the minutes state");
      fail_count++;
    end

  legal_state: assert property (@(posedge clk_i) disable iff (!rstn_i)
    state_i inside {IDLE, CHG_MIN, CHG_TSEC, CHG_SEC, CHG_TENTH})
    else begin
      $error("Set machine in an illegal state");
      fail_count++;
    end

endmodule

bind stopw_top stopw_asserts u_asserts (
  .clk_i       (clk_i),
  .rstn_i      (rstn_i),
  .state_i     (state_value),
  .running_i   (running),
  .passed_all_i(passed_all),
  .wb_ack_i    (wb_ack_o)
);

`default_nettype wire

//--- verification/stopw_tb.sv
`timescale 1ns/10ps
`default_nettype none

module stopw_tb import stopw_pkg::*, stopw_bus_pkg::*; ();

  localparam int TICK_DIV     = 4;
  localparam int PRESS_CYCLES = 6;
  localparam int ACK_TIMEOUT  = 16;
  // Set mode takes about 450 cycles at most, the timed runs about 500.
  localparam int MAX_CYCLES   = 4000;
  localparam int BTN_START    = 0;
  localparam int BTN_SET      = 1;
  localparam int BTN_CHANGE   = 2;

  logic             clk;
  logic             rstn;
  logic             btn_start;
  logic             btn_set;
  logic             btn_change;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_dat_w;
  logic [WB_DW-1:0] wb_dat_r;
  logic             wb_ack;
  logic             run;
  digit_t [3:0]     time_val;

  int         errors;
  int         checks;
  int         cycles;
  int         last_press_cycle;
  int         measured;
  logic [7:0] lfsr_q;

  stopw_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clk_gen (
    .clk_o (clk),
    .rstn_o(rstn)
  );

  stopw_top #(.TICK_DIV(TICK_DIV)) DUT (
    .clk_i       (clk),
    .rstn_i      (rstn),
    .btn_start_i (btn_start),
    .btn_set_i   (btn_set),
    .btn_change_i(btn_change),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat_w),
    .wb_dat_o    (wb_dat_r),
    .wb_ack_o    (wb_ack),
    .run_o       (run),
    .time_o      (time_val)
  );

  // Taps 8, 6, 5 and 4.
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic draw_bits(input int nbits, output int value);
    int i;
    value = 0;
    for (i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = (value << 1) | int'(lfsr_q[0]);
    end
  endtask

  // Packed as minutes, tens of seconds, seconds, tenths.
  function automatic logic [15:0] tenths_to_bcd(input int t);
    logic [15:0] bcd;
    bcd[3:0]   = 4'(t % 10);
    bcd[7:4]   = 4'((t / 10) % 10);
    bcd[11:8]  = 4'((t / 100) % 6);
    bcd[15:12] = 4'((t / 600) % 10);
    return bcd;
  endfunction

  function automatic logic [15:0] status_word(input int state, input logic running,
                                              input logic passed);
    return {11'b0, passed, running, 3'(state)};
  endfunction

  // Digit 2 is tens of seconds.
  function automatic int digit_modulus(input int d);
    return (d == 2) ? 6 : 10;
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic drive_btn(input int which, input logic level);
    case (which)
      BTN_START: btn_start <= level;
      BTN_SET:   btn_set <= level;
      default:   btn_change <= level;
    endcase
  endtask

  // The button takes effect four edges after it is first driven.
  task automatic press_button(input int which);
    @(posedge clk);
    last_press_cycle = cycles;
    drive_btn(which, 1'b1);
    repeat (2) @(posedge clk);
    drive_btn(which, 1'b0);
    repeat (PRESS_CYCLES - 2) @(posedge clk);
  endtask

  task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] addr,
                           input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
    int wait_cnt;
    wait_cnt = 0;
    rdata    = '0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= addr;
    wb_dat_w <= wdata;
    do begin
      @(negedge clk);
      wait_cnt++;
    end while (!wb_ack && wait_cnt < ACK_TIMEOUT);
    if (wb_ack) begin
      rdata = wb_dat_r;
    end else begin
      errors++;
      $display("No Wishbone ack for the access to address %0d", addr);
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] addr, output logic [WB_DW-1:0] data);
    bus_cycle(1'b0, addr, '0, data);
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] addr, input logic [WB_DW-1:0] data);
    logic [WB_DW-1:0] unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic test_reset();
    logic [WB_DW-1:0] data;
    wb_read(ADDR_TIME, data);
    check_value("TIME", data, 16'h0000);
    check_value("time_o", time_val, 16'h0000);
    wb_read(ADDR_STATUS, data);
    check_value("STATUS", data, 16'h0000);
    check_value("run_o", 16'(run), 16'h0000);
  endtask

  // Tenths first, minutes last, each digit set without carry.
  task automatic test_set_mode();
    logic [WB_DW-1:0] data;
    logic [WB_DW-1:0] exp_time;
    int               d;
    int               n;
    exp_time = '0;
    for (d = 0; d < 4; d++) begin
      press_button(BTN_SET);
      wb_read(ADDR_STATUS, data);
      check_value("STATUS", data, status_word(4 - d, 1'b0, 1'b0));
      draw_bits(4, n);
      repeat (n) press_button(BTN_CHANGE);
      exp_time[d*4 +: 4] = 4'(n % digit_modulus(d));
      wb_read(ADDR_TIME, data);
      check_value("TIME", data, exp_time);
      check_value("time_o", time_val, exp_time);
    end
  endtask

  task automatic test_pass_flag();
    logic [WB_DW-1:0] data;
    press_button(BTN_SET);
    wb_read(ADDR_STATUS, data);
    check_value("STATUS", data, status_word(0, 1'b0, 1'b1));
    wb_read(ADDR_STATUS, data);
    check_value("STATUS", data, status_word(0, 1'b0, 1'b0));
  endtask

  task automatic test_counting(input int k, output int tenths);
    logic [WB_DW-1:0] data;
    int               start_cycle;
    wb_write(ADDR_CTRL, 16'h0001);
    wb_read(ADDR_TIME, data);
    check_value("TIME", data, 16'h0000);
    press_button(BTN_START);
    start_cycle = last_press_cycle;
    check_value("run_o", 16'(run), 16'h0001);
    repeat (k * TICK_DIV - PRESS_CYCLES) @(posedge clk);
    press_button(BTN_START);
    check_value("run_o", 16'(run), 16'h0000);
    tenths = (last_press_cycle - start_cycle) / TICK_DIV;
    wb_read(ADDR_TIME, data);
    check_value("TIME", data, tenths_to_bcd(tenths));
    check_value("time_o", time_val, tenths_to_bcd(tenths));
  endtask

  task automatic test_guards(input int base_tenths);
    logic [WB_DW-1:0] data;
    int               start_cycle;
    int               elapsed;
    press_button(BTN_START);
    start_cycle = last_press_cycle;
    press_button(BTN_SET);
    wb_read(ADDR_STATUS, data);
    check_value("STATUS", data, status_word(0, 1'b1, 1'b0));
    wb_write(ADDR_CTRL, 16'h0001);
    repeat (4 * TICK_DIV) @(posedge clk);
    press_button(BTN_START);
    elapsed = last_press_cycle - start_cycle;
    wb_read(ADDR_TIME, data);
    check_value("TIME", data, tenths_to_bcd(base_tenths + elapsed / TICK_DIV));
    wb_write(ADDR_CTRL, 16'h0001);
    wb_read(ADDR_TIME, data);
    check_value("TIME", data, 16'h0000);
    check_value("time_o", time_val, 16'h0000);
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    errors           = 0;
    checks           = 0;
    last_press_cycle = 0;
    lfsr_q           = 8'd70;
    btn_start  <= 1'b0;
    btn_set    <= 1'b0;
    btn_change <= 1'b0;
    wb_cyc     <= 1'b0;
    wb_stb     <= 1'b0;
    wb_we      <= 1'b0;
    wb_adr     <= '0;
    wb_dat_w   <= '0;
    wait (rstn === 1'b1);
    repeat (2) @(posedge clk);
    test_reset();
    test_set_mode();
    test_pass_flag();
    test_counting(105, measured);
    test_guards(measured);
    errors += DUT.u_asserts.fail_count;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
src/stopw_pkg.sv
src/stopw_bus_pkg.sv
src/stopw_button_sync.sv
src/stopw_finstate.sv
src/stopw_run_ctrl.sv
src/stopw_digit_counter.sv
src/stopw_wb_regs.sv
src/stopw_top.sv
verification/stopw_clk_gen.sv
verification/stopw_asserts.sv
verification/stopw_tb.sv

//--- Bender.yml
package:
  name: stopw

sources:
  - src/stopw_pkg.sv
  - src/stopw_bus_pkg.sv
  - src/stopw_button_sync.sv
  - src/stopw_finstate.sv
  - src/stopw_run_ctrl.sv
  - src/stopw_digit_counter.sv
  - src/stopw_wb_regs.sv
  - src/stopw_top.sv
  - target: test
    files:
      - verification/stopw_clk_gen.sv
      - verification/stopw_asserts.sv
      - verification/stopw_tb.sv
